/* neoPkg.sv */
package neoPkg;

	// Memory map of the 68000 side

	// One palette bank holds 4096 words
	localparam int palBankWords = 4096;

	// Upper address byte of the player input ports (read only)
	localparam logic [7:0] p1Region = 8'h30;
	localparam logic [7:0] p2Region = 8'h34;

	// System latch, upper byte 3A with bits 15..5 clear (write only)
	localparam logic [7:0] sysRegion = 8'h3A;

	// Palette when A22 set and A23 clear
	localparam int palRegionBit = 22;

	// Undriven data bus reads back as all ones
	localparam logic [15:0] openBus = 16'hFFFF;

	// One request on the simplified synchronous 68000 bus
	typedef struct packed {
		logic        req;
		logic        write;
		// Byte lanes, nUDS and nLDS active high
		logic        upperEn;
		logic        lowerEn;
		// Byte address bits 23 to 1
		logic [23:1] addr;
		logic [15:0] wdata;
	} cpuBusReq;

	// Chip selects and decoded fields
	typedef struct packed {
		logic        selP1;
		logic        selP2;
		logic        selSys;
		logic        selPal;
		// Word index inside one bank
		logic [11:0] palAddr;
		// Latch bit number and new value
		logic [2:0]  sysIndex;
		logic        sysValue;
	} busSelect;

	// Addressable latch outputs, MSB first so bit n is latch output n
	typedef struct packed {
		logic palBank;
		logic sramWen;
		logic systemRom;
		logic regEn;
		logic cardWenB;
		logic cardWen;
		logic vecSwap;
		logic shadow;
	} sysFlags;

	// Palette word, raw for the CPU, colour fields for video
	typedef union packed {
		logic [15:0] raw;
		struct packed {
			logic       dark;
			// Shared low bits of each channel
			logic       r0;
			logic       g0;
			logic       b0;
			logic [3:0] rHi;
			logic [3:0] gHi;
			logic [3:0] bHi;
		} fields;
	} palWord;

	// DAC levels, 7 bits per channel
	typedef struct packed {
		logic [6:0] red;
		logic [6:0] green;
		logic [6:0] blue;
	} rgbPixel;

endpackage

/* neoAddrDecode.sv */
module neoAddrDecode import neoPkg::*; (
	input  cpuBusReq cpuBus,
	output busSelect sel
);

	// Top byte of the address picks the chip
	logic [7:0] upperByte;

	// Request direction
	logic isRead;
	logic isWrite;

	// Region hits before direction is applied
	logic inP1;
	logic inP2;
	logic inSys;
	logic inPal;

	assign upperByte = cpuBus.addr[23:16];

	assign isRead  = cpuBus.req && !cpuBus.write;
	assign isWrite = cpuBus.req && cpuBus.write;

	// Input ports decode on the full upper byte
	assign inP1 = (upperByte == p1Region);
	assign inP2 = (upperByte == p2Region);

	// Latch sits in the bottom 32 bytes of its region only
	assign inSys = (upperByte == sysRegion) && (cpuBus.addr[15:5] == '0);

	// Whole 4MB window mirrors the palette
	assign inPal = cpuBus.addr[palRegionBit] && !cpuBus.addr[palRegionBit + 1];

	always_comb begin
		// Inputs only answer reads
		sel.selP1 = isRead && inP1;
		sel.selP2 = isRead && inP2;

		// Latch only reacts to writes, reads fall to open bus
		sel.selSys = isWrite && inSys;

		// Palette takes both directions
		sel.selPal = cpuBus.req && inPal;

		// A12..A1, higher bits ignored so the region mirrors
		sel.palAddr = cpuBus.addr[12:1];

		// A4..A2 pick the latch output
		sel.sysIndex = cpuBus.addr[4:2];
		// A1 is the data bit
		sel.sysValue = cpuBus.addr[1];
	end

endmodule

/* neoSysLatch.sv */
module neoSysLatch import neoPkg::*; (
	input  logic     CLK_24M,
	input  logic     reset,
	input  busSelect sel,
	output sysFlags  flags
);

	// Latch contents, bit n drives output n
	logic [7:0] latchBits;

	// Addressable latch, one bit per write
	always_ff @(posedge CLK_24M) begin
		if (reset) begin
			latchBits <= '0;
		end else if (sel.selSys) begin
			// Other bits keep their state
			latchBits[sel.sysIndex] <= sel.sysValue;
		end
	end

	// Same bit order as the struct
	assign flags = sysFlags'(latchBits);

endmodule

/* neoPalRam.sv */
module neoPalRam import neoPkg::*; (
	input  logic        CLK_24M,
	input  cpuBusReq    cpuBus,
	input  busSelect    sel,
	input  logic        palBank,
	input  logic [11:0] pixelIndex,
	output palWord      cpuRdata,
	output palWord      vidWord
);

	// Both banks in one array, bank bit on top
	logic [15:0] palMem [0:2*palBankWords-1];

	// CPU side address and write strobe
	logic [12:0] cpuAddr;
	logic        cpuWrite;

	// Addresses held for the registered reads
	logic [12:0] cpuAddrQ;
	logic [12:0] vidAddrQ;

	// Bank as it stands before the request edge
	assign cpuAddr  = {palBank, sel.palAddr};
	assign cpuWrite = sel.selPal && cpuBus.write;

	// Byte lane writes
	always_ff @(posedge CLK_24M) begin
		if (cpuWrite && cpuBus.upperEn) begin
			palMem[cpuAddr][15:8] <= cpuBus.wdata[15:8];
		end
		if (cpuWrite && cpuBus.lowerEn) begin
			palMem[cpuAddr][7:0] <= cpuBus.wdata[7:0];
		end
	end

	// CPU read, address at the request edge, data one edge later
	always_ff @(posedge CLK_24M) begin
		cpuAddrQ     <= cpuAddr;
		cpuRdata.raw <= palMem[cpuAddrQ];
	end

	// Video lookup, bank taken together with the index
	always_ff @(posedge CLK_24M) begin
		vidAddrQ <= {palBank, pixelIndex};
		// Read first, a write on the same edge is not seen yet
		vidWord.raw <= palMem[vidAddrQ];
	end

endmodule

/* neoReadPath.sv */
module neoReadPath import neoPkg::*; (
	input  logic        CLK_24M,
	input  logic        reset,
	input  cpuBusReq    cpuBus,
	input  busSelect    sel,
	input  logic [7:0]  p1In,
	input  logic [7:0]  p2In,
	input  logic [7:0]  dipSw,
	input  palWord      palData,
	output logic [15:0] readData,
	output logic        readValid
);

	logic        isRead;
	// Word for every source other than the palette
	logic [15:0] inWord;

	// Two stages, matching the palette RAM latency
	logic        validQ1;
	logic        validQ2;
	logic        palQ1;
	logic        palQ2;
	logic [15:0] wordQ1;
	logic [15:0] wordQ2;

	assign isRead = cpuBus.req && !cpuBus.write;

	// Input ports sampled at the request edge
	always_comb begin
		if (sel.selP1) begin
			// DIP switches share the P1 word
			inWord = {p1In, dipSw};
		end else if (sel.selP2) begin
			// Nothing on the low byte
			inWord = {p2In, 8'hFF};
		end else begin
			inWord = openBus;
		end
	end

	// Read strobe pipeline
	always_ff @(posedge CLK_24M) begin
		if (reset) begin
			validQ1   <= 1'b0;
			validQ2   <= 1'b0;
			readValid <= 1'b0;
		end else begin
			validQ1   <= isRead;
			validQ2   <= validQ1;
			readValid <= validQ2;
		end
	end

	// Source choice travels with the strobe
	always_ff @(posedge CLK_24M) begin
		palQ1  <= sel.selPal;
		wordQ1 <= inWord;
		palQ2  <= palQ1;
		wordQ2 <= wordQ1;
		// Palette word is ready in the second stage
		readData <= palQ2 ? palData.raw : wordQ2;
	end

endmodule

/* neoVideoOut.sv */
module neoVideoOut import neoPkg::*; (
	input  logic    CLK_24M,
	input  logic    reset,
	input  logic    pixelValid,
	input  palWord  vidWord,
	input  logic    shadow,
	output rgbPixel rgbOut,
	output logic    videoValid
);

	// Pixel strobe through two stages to meet the RAM word
	logic    pixelQ;
	logic    validQ;
	// Shadow in step with the RAM word
	logic    shadowQ;
	rgbPixel nextRgb;

	// Five-bit value times 4 plus 2 unless dark and halved under shadow
	function automatic logic [6:0] chanLevel(
		input logic [3:0] hi,
		input logic       lo,
		input logic       dark,
		input logic       halve
	);
		logic [6:0] level;
		level = {hi, lo, ~dark, 1'b0};
		// Shadow resistor halves the DAC swing
		if (halve) begin
			level = level >> 1;
		end
		return level;
	endfunction

	// Colour fields of the union
	always_comb begin
		nextRgb.red   = chanLevel(vidWord.fields.rHi, vidWord.fields.r0,
			vidWord.fields.dark, shadowQ);
		nextRgb.green = chanLevel(vidWord.fields.gHi, vidWord.fields.g0,
			vidWord.fields.dark, shadowQ);
		nextRgb.blue  = chanLevel(vidWord.fields.bHi, vidWord.fields.b0,
			vidWord.fields.dark, shadowQ);
	end

	always_ff @(posedge CLK_24M) begin
		if (reset) begin
			pixelQ     <= 1'b0;
			validQ     <= 1'b0;
			shadowQ    <= 1'b0;
			videoValid <= 1'b0;
			rgbOut     <= '0;
		end else begin
			pixelQ     <= pixelValid;
			validQ     <= pixelQ;
			shadowQ    <= shadow;
			videoValid <= validQ;
			// Hold the last colour between pixels
			if (validQ) begin
				rgbOut <= nextRgb;
			end
		end
	end

endmodule

/* neoSubsystem.sv */
module neoSubsystem import neoPkg::*; (
	input  logic        CLK_24M,
	input  logic        reset,
	input  cpuBusReq    cpuBus,
	input  logic [7:0]  p1In,
	input  logic [7:0]  p2In,
	input  logic [7:0]  dipSw,
	input  logic        pixelValid,
	input  logic [11:0] pixelIndex,
	output logic [15:0] readData,
	output logic        readValid,
	output sysFlags     sysStatus,
	output rgbPixel     rgbOut,
	output logic        videoValid
);

	busSelect sel;
	sysFlags  flags;
	// Palette RAM outputs
	palWord   cpuRdata;
	palWord   vidWord;

	neoAddrDecode addrDecode (
		.cpuBus (cpuBus),
		.sel    (sel)
	);

	neoSysLatch sysLatch (
		.CLK_24M (CLK_24M),
		.reset   (reset),
		.sel     (sel),
		.flags   (flags)
	);

	// PALBNK from the latch picks the bank
	neoPalRam palRam (
		.CLK_24M    (CLK_24M),
		.cpuBus     (cpuBus),
		.sel        (sel),
		.palBank    (flags.palBank),
		.pixelIndex (pixelIndex),
		.cpuRdata   (cpuRdata),
		.vidWord    (vidWord)
	);

	neoReadPath readPath (
		.CLK_24M   (CLK_24M),
		.reset     (reset),
		.cpuBus    (cpuBus),
		.sel       (sel),
		.p1In      (p1In),
		.p2In      (p2In),
		.dipSw     (dipSw),
		.palData   (cpuRdata),
		.readData  (readData),
		.readValid (readValid)
	);

	// SHADOW from the latch dims the output
	neoVideoOut videoOut (
		.CLK_24M    (CLK_24M),
		.reset      (reset),
		.pixelValid (pixelValid),
		.vidWord    (vidWord),
		.shadow     (flags.shadow),
		.rgbOut     (rgbOut),
		.videoValid (videoValid)
	);

	assign sysStatus = flags;

endmodule

/* tbNeo.sv */
module tbNeo import neoPkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	// Entry kinds of the stimulus table
	localparam logic [1:0] kindWrite = 2'd0;
	localparam logic [1:0] kindRead = 2'd1;
	localparam logic [1:0] kindPixel = 2'd2;
	localparam logic [1:0] kindInputs = 2'd3;

	// addr holds {p1, p2, dip} for an inputs entry
	typedef struct packed {
		logic [1:0]  kind;
		logic [23:0] addr;
		logic [15:0] data;
		logic [1:0]  lanes;
		logic [31:0] expVal;
	} stimEntry;

	logic        CLK_24M;
	logic        reset;
	cpuBusReq    cpuBus;
	logic [7:0]  p1In;
	logic [7:0]  p2In;
	logic [7:0]  dipSw;
	logic        pixelValid;
	logic [11:0] pixelIndex;
	logic [15:0] readData;
	logic        readValid;
	sysFlags     sysStatus;
	rgbPixel     rgbOut;
	logic        videoValid;

	// Reference model state
	logic [15:0] modelPal [0:8191];
	logic [7:0]  modelFlags;
	logic [7:0]  modelP1;
	logic [7:0]  modelP2;
	logic [7:0]  modelDip;
	logic [31:0] lcgState;
	stimEntry    stimTable [$];

	neoSubsystem neoSubsystem_inst (
		.CLK_24M    (CLK_24M),
		.reset      (reset),
		.cpuBus     (cpuBus),
		.p1In       (p1In),
		.p2In       (p2In),
		.dipSw      (dipSw),
		.pixelValid (pixelValid),
		.pixelIndex (pixelIndex),
		.readData   (readData),
		.readValid  (readValid),
		.sysStatus  (sysStatus),
		.rgbOut     (rgbOut),
		.videoValid (videoValid)
	);

	initial begin
		CLK_24M = 1'b0;
		forever #50 CLK_24M = ~CLK_24M;
	end

	function automatic logic [15:0] lcgNext();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState[31:16];
	endfunction

	// Channel level from the colour rule
	function automatic logic [6:0] modelLevel(input logic [4:0] value, input logic dark,
		input logic shade);
		int level;
		level = value * 4 + (dark ? 0 : 2);
		if (shade) begin
			level = level / 2;
		end
		return level[6:0];
	endfunction

	function automatic void pushEntry(input logic [1:0] kind, input logic [23:0] addr,
		input logic [15:0] data, input logic [1:0] lanes, input logic [31:0] expVal);
		stimEntry e;
		e.kind = kind;
		e.addr = addr;
		e.data = data;
		e.lanes = lanes;
		e.expVal = expVal;
		stimTable.push_back(e);
	endfunction

	// Expected value of a bus write is the flag byte afterwards
	function automatic void addWrite(input logic [23:0] addr, input logic [15:0] data,
		input logic [1:0] lanes);
		logic [12:0] idx;
		idx = {modelFlags[7], addr[12:1]};
		if (!addr[23] && addr[22]) begin
			if (lanes[1]) begin
				modelPal[idx][15:8] = data[15:8];
			end
			if (lanes[0]) begin
				modelPal[idx][7:0] = data[7:0];
			end
		end else if (addr[23:16] == 8'h3A && addr[15:5] == 11'd0) begin
			modelFlags[addr[4:2]] = addr[1];
		end
		pushEntry(kindWrite, addr, data, lanes, {24'd0, modelFlags});
	endfunction

	function automatic void addRead(input logic [23:0] addr);
		logic [15:0] value;
		if (addr[23:16] == 8'h30) begin
			value = {modelP1, modelDip};
		end else if (addr[23:16] == 8'h34) begin
			value = {modelP2, 8'hFF};
		end else if (!addr[23] && addr[22]) begin
			value = modelPal[{modelFlags[7], addr[12:1]}];
		end else begin
			value = 16'hFFFF;
		end
		pushEntry(kindRead, addr, 16'd0, 2'b00, {16'd0, value});
	endfunction

	function automatic void addPixel(input logic [11:0] index);
		logic [15:0] w;
		logic [20:0] rgb;
		w = modelPal[{modelFlags[7], index}];
		rgb = {modelLevel({w[11:8], w[14]}, w[15], modelFlags[0]),
			modelLevel({w[7:4], w[13]}, w[15], modelFlags[0]),
			modelLevel({w[3:0], w[12]}, w[15], modelFlags[0])};
		pushEntry(kindPixel, {12'd0, index}, 16'd0, 2'b00, {11'd0, rgb});
	endfunction

	task automatic reportFailure(input string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	// One-cycle request strobe
	task automatic busCycle(input logic wr, input logic [23:0] addr, input logic [15:0] data,
		input logic [1:0] lanes);
		cpuBus.req = 1'b1;
		cpuBus.write = wr;
		cpuBus.upperEn = lanes[1];
		cpuBus.lowerEn = lanes[0];
		cpuBus.addr = addr[23:1];
		cpuBus.wdata = data;
		@(posedge CLK_24M);
		#5;
		cpuBus = '0;
	endtask

	// Spread indices over the bank
	function automatic logic [11:0] wordIndex(input int i);
		return 12'(i * 12'h247);
	endfunction

	function automatic void buildTable();
		logic [15:0] data;
		modelP1 = 8'hA5;
		modelP2 = 8'h3C;
		modelDip = 8'h96;
		pushEntry(kindInputs, {modelP1, modelP2, modelDip}, 16'd0, 2'b00, 32'd0);
		// Full words with the dark bit alternating
		for (int i = 0; i < 8; i++) begin
			data = lcgNext();
			data[15] = i[0];
			addWrite({11'h200, wordIndex(i), 1'b0}, data, 2'b11);
			addRead({11'h200, wordIndex(i), 1'b0});
		end
		// Single lane merges
		addWrite({11'h200, wordIndex(0), 1'b0}, lcgNext(), 2'b10);
		addRead({11'h200, wordIndex(0), 1'b0});
		addWrite({11'h200, wordIndex(1), 1'b0}, lcgNext(), 2'b01);
		addRead({11'h200, wordIndex(1), 1'b0});
		// Mirrors of the same words
		for (int i = 0; i < 4; i++) begin
			addRead({11'h201, wordIndex(i), 1'b0});
			addRead({11'h3FF, wordIndex(i), 1'b0});
		end
		for (int i = 0; i < 8; i++) begin
			addPixel(wordIndex(i));
		end
		addRead(24'h300000);
		addRead(24'h340000);
		addRead(24'h30FFFE);
		addRead(24'h000100);
		addRead(24'h800000);
		addRead(24'h3A0002);
		// Latch set and clear with 3A0022 lying outside the latch
		addWrite(24'h3A0002, 16'd0, 2'b11);
		addWrite(24'h3A0006, 16'd0, 2'b11);
		addWrite(24'h3A0022, 16'd0, 2'b11);
		addWrite(24'h3A0004, 16'd0, 2'b11);
		for (int i = 0; i < 8; i++) begin
			addPixel(wordIndex(i));
		end
		addWrite(24'h3A0000, 16'd0, 2'b11);
		// Second bank
		addWrite(24'h3A001E, 16'd0, 2'b11);
		for (int i = 0; i < 4; i++) begin
			addWrite({11'h200, wordIndex(i), 1'b0}, lcgNext(), 2'b11);
			addRead({11'h200, wordIndex(i), 1'b0});
			addPixel(wordIndex(i));
		end
		// First bank left as it was
		addWrite(24'h3A001C, 16'd0, 2'b11);
		for (int i = 0; i < 4; i++) begin
			addRead({11'h200, wordIndex(i), 1'b0});
			addPixel(wordIndex(i));
		end
	endfunction

	initial begin
		stimEntry e;
		int cycles;
		reset = 1'b1;
		cpuBus = '0;
		p1In = '0;
		p2In = '0;
		dipSw = '0;
		pixelValid = 1'b0;
		pixelIndex = '0;
		modelFlags = '0;
		lcgState = 32'd77;
		buildTable();
		repeat (16) @(posedge CLK_24M);
		#5;
		reset = 1'b0;
		assert (!readValid && !videoValid && sysStatus == '0 && rgbOut == '0) else
			reportFailure($sformatf(
				"mismatch reset state: readValid %h videoValid %h sysStatus %h rgbOut %h",
				readValid, videoValid, sysStatus, rgbOut));
		foreach (stimTable[n]) begin
			e = stimTable[n];
			cycles = 0;
			case (e.kind)
				kindInputs: begin
					{p1In, p2In, dipSw} = e.addr;
					@(posedge CLK_24M);
					#5;
				end
				kindWrite: begin
					busCycle(1'b1, e.addr, e.data, e.lanes);
					assert (sysStatus == e.expVal[7:0]) else
						reportFailure($sformatf("mismatch sysStatus: got %h expected %h",
							sysStatus, e.expVal[7:0]));
				end
				kindRead: begin
					busCycle(1'b0, e.addr, 16'd0, 2'b00);
					while (!readValid) begin
						if (cycles >= 20) begin
							reportFailure("timeout, readValid never came");
						end
						@(posedge CLK_24M);
						#5;
						cycles++;
					end
					assert (cycles == 2) else
						reportFailure($sformatf("mismatch readValid latency: got %h expected %h",
							cycles, 2));
					assert (readData == e.expVal[15:0]) else
						reportFailure($sformatf("mismatch readData at %h: got %h expected %h",
							e.addr, readData, e.expVal[15:0]));
				end
				default: begin
					pixelValid = 1'b1;
					pixelIndex = e.addr[11:0];
					@(posedge CLK_24M);
					#5;
					pixelValid = 1'b0;
					while (!videoValid) begin
						if (cycles >= 20) begin
							reportFailure("timeout, videoValid never came");
						end
						@(posedge CLK_24M);
						#5;
						cycles++;
					end
					assert (cycles == 2) else
						reportFailure($sformatf("mismatch videoValid latency: got %h expected %h",
							cycles, 2));
					assert (rgbOut == e.expVal[20:0]) else
						reportFailure($sformatf("mismatch rgbOut at %h: got %h expected %h",
							e.addr[11:0], rgbOut, e.expVal[20:0]));
				end
			endcase
		end
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

/* all.f */
neoPkg.sv
neoAddrDecode.sv
neoSysLatch.sv
neoPalRam.sv
neoReadPath.sv
neoVideoOut.sv
neoSubsystem.sv
tbNeo.sv
